// ==== sim.f ====
+incdir+include
hw/vec_pkg.sv
hw/vec_issue_queue.sv
hw/vec_lane.sv
hw/vec_wb_merge.sv
hw/vec_unit_top.sv
tests/tb_vec_unit.sv

// ==== tests/tb_vec_unit.sv ====
`timescale 1ns/10ps
`include "vec_cfg.svh"

module tb_vec_unit;

    localparam int STIM_CYCLES = 64 * 3 + 128 + 32;
    localparam int CYCLE_LIMIT = 10 * STIM_CYCLES;

    // Expected ALU write with its overflow pulse
    typedef struct packed {
        logic             ovf;
        vec_pkg::vec_wb_t wb;
    } exp_t;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                issue_valid;
    vec_pkg::vec_issue_t issue;
    logic                issue_full;
    logic [`VMASK_W-1:0] vmask;
    logic                load_wb_valid;
    vec_pkg::vec_wb_t    load_wb;
    logic                vwb_valid;
    vec_pkg::vec_wb_t    vwb;
    logic                err_vec_overflow;

    integer seed = 32'h0466_3762;
    int     cycles = 0;
    logic   lat_chk = 1'b0;

    // Model of queued instructions and of results in lanes or pending
    vec_pkg::vec_issue_t mq[$];
    exp_t                exp_q[$];
    exp_t                exp_front;
    int                  m_qcnt = 0;
    logic                m_lane_v = 1'b0;
    logic                m_pend_v = 1'b0;

    vec_unit_top i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .issue_valid      (issue_valid),
        .issue            (issue),
        .issue_full       (issue_full),
        .vmask            (vmask),
        .load_wb_valid    (load_wb_valid),
        .load_wb          (load_wb),
        .vwb_valid        (vwb_valid),
        .vwb              (vwb),
        .err_vec_overflow (err_vec_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [127:0] rand_vec();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // --------------------------------------------------
    // Reference model of one vector instruction
    // --------------------------------------------------
    function automatic exp_t model_result(input vec_pkg::vec_issue_t ins,
                                          input logic [`VMASK_W-1:0] m);
        exp_t   e;
        int     n;
        longint a;
        longint b;
        longint r;
        longint lim;
        logic   on;
        e.ovf     = 1'b0;
        e.wb.rd   = ins.rd;
        e.wb.data = ins.src_a;
        n   = (ins.elem_w == vec_pkg::EW16) ? 8 : 4;
        lim = (n == 8) ? 64'sd32768 : 64'sd2147483648;
        for (int i = 0; i < n; i++) begin
            if (n == 8) begin
                a  = longint'($signed(ins.src_a[16*i +: 16]));
                b  = longint'($signed(ins.src_b[16*i +: 16]));
                on = m[i];
            end else begin
                a  = longint'($signed(ins.src_a[32*i +: 32]));
                b  = longint'($signed(ins.src_b[32*i +: 32]));
                on = m[2*i];
            end
            case (ins.op)
                vec_pkg::OP_ADD: r = a + b;
                vec_pkg::OP_SUB: r = a - b;
                vec_pkg::OP_MAX: r = (a > b) ? a : b;
                default:         r = a & b;
            endcase
            if (!ins.vm_enable || on) begin
                if (n == 8) begin
                    e.wb.data[16*i +: 16] = r[15:0];
                end else begin
                    e.wb.data[32*i +: 32] = r[31:0];
                end
                // Out of the element's signed range
                if (r >= lim || r < -lim) begin
                    e.ovf = 1'b1;
                end
            end
        end
        return e;
    endfunction

    // Pipeline model stepped on each edge from the sampled inputs
    always @(posedge clk or negedge rst_n) begin : model
        logic ready;
        logic pop;
        logic acc;
        logic park;
        if (!rst_n) begin
            mq.delete();
            exp_q.delete();
            m_lane_v = 1'b0;
            m_pend_v = 1'b0;
        end else begin
            ready = !m_pend_v && !(m_lane_v && load_wb_valid);
            pop   = (mq.size() != 0) && ready;
            acc   = issue_valid && !flush && (mq.size() != `VQ_DEPTH);
            park  = m_lane_v && (load_wb_valid || m_pend_v);
            if (!load_wb_valid && (m_pend_v || m_lane_v)) begin
                void'(exp_q.pop_front());
            end
            if (m_pend_v && !load_wb_valid) begin
                m_pend_v = 1'b0;
            end
            if (park) begin
                m_pend_v = 1'b1;
            end
            m_lane_v = pop;
            if (pop) begin
                exp_q.push_back(model_result(mq.pop_front(), vmask));
            end
            if (flush) begin
                mq.delete();
            end else if (acc) begin
                mq.push_back(issue);
            end
        end
        m_qcnt = mq.size();
        if (exp_q.size() != 0) begin
            exp_front = exp_q[0];
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        vwb_valid == (load_wb_valid || m_pend_v || m_lane_v))
        else begin
            $display("mismatch vwb_valid: expected %h, got %h",
                     $sampled(load_wb_valid || m_pend_v || m_lane_v), $sampled(vwb_valid));
            stop_on_error();
        end

    a_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_wb_valid |-> vwb == load_wb)
        else begin
            $display("mismatch vwb on load: expected %h, got %h",
                     $sampled(load_wb), $sampled(vwb));
            stop_on_error();
        end

    a_load_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        load_wb_valid |-> !err_vec_overflow)
        else begin
            $display("overflow error raised on a load write");
            stop_on_error();
        end

    a_alu_data: assert property (@(posedge clk) disable iff (!rst_n)
        (vwb_valid && !load_wb_valid) |-> vwb == exp_front.wb)
        else begin
            $display("mismatch vwb: expected %h, got %h",
                     $sampled(exp_front.wb), $sampled(vwb));
            stop_on_error();
        end

    a_alu_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        (vwb_valid && !load_wb_valid) |-> err_vec_overflow == exp_front.ovf)
        else begin
            $display("mismatch err_vec_overflow: expected %h, got %h",
                     $sampled(exp_front.ovf), $sampled(err_vec_overflow));
            stop_on_error();
        end

    a_idle_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        !vwb_valid |-> !err_vec_overflow)
        else begin
            $display("overflow error raised with no write on the port");
            stop_on_error();
        end

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        issue_full == (m_qcnt == `VQ_DEPTH))
        else begin
            $display("mismatch issue_full: expected %h, got %h",
                     $sampled(m_qcnt == `VQ_DEPTH), $sampled(issue_full));
            stop_on_error();
        end

    // Two-cycle latency while the load port is idle
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (lat_chk && issue_valid && !issue_full && !flush) |-> ##2 vwb_valid)
        else begin
            $display("ALU result did not arrive two cycles after issue");
            stop_on_error();
        end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles", cycles);
            stop_on_error();
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_cycle(input bit iss, input bit ld, input bit ew16, input bit vm);
        issue_valid     = iss && !issue_full;
        issue.op        = vec_pkg::vec_op_e'(2'($random(seed)));
        issue.elem_w    = ew16 ? vec_pkg::EW16 : vec_pkg::EW32;
        issue.vm_enable = vm;
        issue.rd        = $random(seed);
        issue.src_a     = rand_vec();
        issue.src_b     = rand_vec();
        vmask           = $random(seed);
        load_wb_valid   = ld;
        load_wb.rd      = $random(seed);
        load_wb.data    = rand_vec();
        next_cycle();
    endtask

    task automatic wait_drain();
        issue_valid   = 1'b0;
        load_wb_valid = 1'b0;
        while (mq.size() != 0 || exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    initial begin
        rst_n         = 1'b0;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        vmask         = '0;
        load_wb_valid = 1'b0;
        load_wb       = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        lat_chk = 1'b1;
        next_cycle();

        // 32-bit, then 16-bit, then masked elements
        repeat (64) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
        wait_drain();
        repeat (64) drive_cycle(1'b1, 1'b0, 1'b1, 1'b0);
        wait_drain();
        repeat (64) drive_cycle(1'b1, 1'b0, $random(seed), 1'b1);
        wait_drain();

        // Loads colliding with ALU results
        lat_chk = 1'b0;
        repeat (128) drive_cycle($random(seed), $random(seed), $random(seed), $random(seed));
        wait_drain();

        // Load stream holds the ALU until the queue fills and a flush follows
        while (!issue_full) begin
            drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        end
        issue_valid = 1'b0;
        flush       = 1'b1;
        next_cycle();
        flush       = 1'b0;
        wait_drain();

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== hw/vec_unit_top.sv ====
`timescale 1ns/10ps
`include "vec_cfg.svh"

module vec_unit_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                issue_valid,
    input  vec_pkg::vec_issue_t issue,
    output logic                issue_full,
    input  logic [`VMASK_W-1:0] vmask,
    input  logic                load_wb_valid,
    input  vec_pkg::vec_wb_t    load_wb,
    output logic                vwb_valid,
    output vec_pkg::vec_wb_t    vwb,
    output logic                err_vec_overflow
);

    logic                head_valid;
    vec_pkg::vec_issue_t head;
    logic                alu_ready;
    logic                lane_in_valid;

    // Per-lane outputs with the same valid and rd in every lane
    logic [`VEC_LANES-1:0]         lane_res_valid;
    logic [`VREG_IDX_W-1:0]        lane_res_rd [`VEC_LANES];
    logic [`VEC_LANES-1:0][31:0]   lane_result;
    logic [`VEC_LANES-1:0]         lane_ovf;

    vec_pkg::vec_wb_t alu_wb;

    vec_issue_queue i_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .push_valid (issue_valid),
        .push       (issue),
        .full       (issue_full),
        .head_valid (head_valid),
        .head       (head),
        .pop_ready  (alu_ready)
    );

    assign lane_in_valid = head_valid && alu_ready;

    // --------------------------------------------------
    // ALU lanes with one 32-bit slice each
    // --------------------------------------------------
    for (genvar g = 0; g < `VEC_LANES; g++) begin : g_lane
        vec_lane i_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid),
            .op        (head.op),
            .elem_w    (head.elem_w),
            .vm_enable (head.vm_enable),
            .rd        (head.rd),
            .src_a     (head.src_a[32*g +: 32]),
            .src_b     (head.src_b[32*g +: 32]),
            .mask      (vmask[2*g +: 2]),
            .res_valid (lane_res_valid[g]),
            .res_rd    (lane_res_rd[g]),
            .result    (lane_result[g]),
            .overflow  (lane_ovf[g])
        );
    end

    // Lane 0 speaks for the whole vector
    assign alu_wb.rd   = lane_res_rd[0];
    assign alu_wb.data = lane_result;

    vec_wb_merge i_merge (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_valid   (load_wb_valid),
        .load         (load_wb),
        .alu_valid    (lane_res_valid[0]),
        .alu          (alu_wb),
        .alu_overflow (|lane_ovf),
        .alu_ready    (alu_ready),
        .wb_valid     (vwb_valid),
        .wb           (vwb),
        .err_overflow (err_vec_overflow)
    );

endmodule

// ==== hw/vec_wb_merge.sv ====
`timescale 1ns/10ps
`include "vec_cfg.svh"

module vec_wb_merge (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_valid,
    input  vec_pkg::vec_wb_t load,
    input  logic             alu_valid,
    input  vec_pkg::vec_wb_t alu,
    input  logic             alu_overflow,
    output logic             alu_ready,
    output logic             wb_valid,
    output vec_pkg::vec_wb_t wb,
    output logic             err_overflow
);

    // Pending skid entry
    logic             pend_valid;
    vec_pkg::vec_wb_t pend;
    logic             pend_ovf;

    logic pend_take;
    logic alu_take;
    logic alu_park;

    // --------------------------------------------------
    // Port arbitration with load before pending before ALU
    // --------------------------------------------------
    assign pend_take = pend_valid && !load_valid;
    assign alu_take  = alu_valid && !load_valid && !pend_valid;

    // ALU result that lost the port is kept in pending
    assign alu_park  = alu_valid && !alu_take;

    always_comb begin
        wb_valid = load_valid || pend_valid || alu_valid;
        if (load_valid) begin
            wb = load;
        end else if (pend_valid) begin
            wb = pend;
        end else begin
            wb = alu;
        end
    end

    // Only ALU writes carry the overflow pulse
    assign err_overflow = (pend_take && pend_ovf) || (alu_take && alu_overflow);

    // Hold the lanes while pending is occupied or about to be
    assign alu_ready = !pend_valid && !(alu_valid && load_valid);

    // --------------------------------------------------
    // Pending buffer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else begin
            if (pend_take) begin
                pend_valid <= 1'b0;
            end
            if (alu_park) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_park) begin
            pend     <= alu;
            pend_ovf <= alu_overflow;
        end
    end

endmodule

// ==== hw/vec_lane.sv ====
`timescale 1ns/10ps
`include "vec_cfg.svh"

module vec_lane (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  vec_pkg::vec_op_e       op,
    input  vec_pkg::elem_w_e       elem_w,
    input  logic                   vm_enable,
    input  logic [`VREG_IDX_W-1:0] rd,
    input  logic [31:0]            src_a,
    input  logic [31:0]            src_b,
    input  logic [1:0]             mask,
    output logic                   res_valid,
    output logic [`VREG_IDX_W-1:0] res_rd,
    output logic [31:0]            result,
    output logic                   overflow
);

    vec_pkg::lane_word_u a_u;
    vec_pkg::lane_word_u b_u;
    vec_pkg::lane_word_u r_u;

    logic [31:0] r_e;
    logic        ovf_e;
    logic        ovf_any;

    // Returns {signed overflow, result} for one 32-bit element.
    // A 16-bit element is passed in the upper half with zeros below,
    // so the same sign bit, carry-out and compare apply to it
    function automatic logic [32:0] elem_alu(
        input vec_pkg::vec_op_e f_op,
        input logic [31:0]      a,
        input logic [31:0]      b
    );
        logic [31:0] r;
        logic        ovf;
        r   = '0;
        ovf = 1'b0;
        case (f_op)
            vec_pkg::OP_ADD: begin
                r   = a + b;
                ovf = (a[31] == b[31]) && (r[31] != a[31]);
            end
            vec_pkg::OP_SUB: begin
                r   = a - b;
                ovf = (a[31] != b[31]) && (r[31] != a[31]);
            end
            vec_pkg::OP_MAX: r = ($signed(a) > $signed(b)) ? a : b;
            default:         r = a & b;
        endcase
        return {ovf, r};
    endfunction

    assign a_u.word = src_a;
    assign b_u.word = src_b;

    // --------------------------------------------------
    // Element compute and masking
    // --------------------------------------------------
    always_comb begin
        r_u     = a_u;
        r_e     = '0;
        ovf_e   = 1'b0;
        ovf_any = 1'b0;
        if (elem_w == vec_pkg::EW32) begin
            {ovf_e, r_e} = elem_alu(op, a_u.word, b_u.word);
            // Only the low mask bit of the pair governs a 32-bit element
            if (!vm_enable || mask[0]) begin
                r_u.word = r_e;
                ovf_any  = ovf_e;
            end
        end else begin
            for (int h = 0; h < 2; h++) begin
                {ovf_e, r_e} = elem_alu(op, {a_u.half[h], 16'h0}, {b_u.half[h], 16'h0});
                if (!vm_enable || mask[h]) begin
                    r_u.half[h] = r_e[31:16];
                    ovf_any     = ovf_any | ovf_e;
                end
            end
        end
    end

    // One-cycle result stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            res_rd   <= rd;
            result   <= r_u.word;
            overflow <= ovf_any;
        end
    end

endmodule

// ==== hw/vec_issue_queue.sv ====
`timescale 1ns/10ps
`include "vec_cfg.svh"

module vec_issue_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                push_valid,
    input  vec_pkg::vec_issue_t push,
    output logic                full,
    output logic                head_valid,
    output vec_pkg::vec_issue_t head,
    input  logic                pop_ready
);

    localparam int PTR_W = (`VQ_DEPTH > 1) ? $clog2(`VQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`VQ_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`VQ_DEPTH - 1);

    vec_pkg::vec_issue_t entries [`VQ_DEPTH];

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // Wrap at the last slot so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == LAST_PTR) ? '0 : p + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(`VQ_DEPTH));
    assign head_valid = (count != '0);
    assign head       = entries[head_ptr];

    // An issue while full or during a flush is dropped
    assign do_push = push_valid && !full && !flush;
    assign do_pop  = head_valid && pop_ready;

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            // A taken branch discards everything still queued
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            if (do_push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[tail_ptr] <= push;
        end
    end

endmodule

// ==== hw/vec_pkg.sv ====
`include "vec_cfg.svh"

package vec_pkg;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    // ALU operation with MAX as a signed maximum
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MAX = 2'd2,
        OP_AND = 2'd3
    } vec_op_e;

    // Element width inside each 32-bit lane
    typedef enum logic {
        EW32 = 1'b0,
        EW16 = 1'b1
    } elem_w_e;

    // One lane slice read as a word or as two 16-bit halves
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
    } lane_word_u;

    // --------------------------------------------------
    // Transfer records
    // --------------------------------------------------

    // Decoded vector instruction with both operands
    typedef struct packed {
        vec_op_e                 op;
        elem_w_e                 elem_w;
        logic                    vm_enable;
        logic [`VREG_IDX_W-1:0]  rd;
        logic [`VEC_W-1:0]       src_a;
        logic [`VEC_W-1:0]       src_b;
    } vec_issue_t;

    // One write on the vector register-file port
    typedef struct packed {
        logic [`VREG_IDX_W-1:0]  rd;
        logic [`VEC_W-1:0]       data;
    } vec_wb_t;

endpackage

// ==== include/vec_cfg.svh ====
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// --------------------------------------------------
// Vector unit sizing
// --------------------------------------------------

// Width of one vector register
`define VEC_W       128

// Number of 32-bit ALU lanes across the vector
`define VEC_LANES   4

// Entries in the vector issue queue
`define VQ_DEPTH    2

// Register index width
`define VREG_IDX_W  5

// One mask bit per 16-bit element
`define VMASK_W     8

`endif
